// ==== tb/queens_testdata.txt ====
// Hex digits: row1 col1 row2 col2, then the expected column for rows 0 to 7
// Fixed queens are given in the order they are driven
0 0 1 4  0 4 7 5 2 6 1 3
7 4 0 0  0 5 7 2 6 3 1 4
2 4 4 1  0 6 4 7 1 3 5 2
4 0 3 3  1 4 6 3 0 7 5 2
3 0 6 6  1 7 5 0 2 4 6 3
2 2 5 4  1 6 2 5 7 4 0 3
1 1 6 2  3 1 4 7 5 0 2 6
// Row 0 has to climb several columns before these resolve
3 7 5 4  3 6 2 7 1 4 0 5
7 7 0 3  3 6 4 1 5 0 2 7
7 0 6 4  3 1 6 2 5 7 4 0
5 3 2 5  4 1 5 0 6 3 7 2
7 6 1 2  4 2 0 5 7 1 3 6
0 6 7 5  6 1 3 0 7 4 2 5
7 4 0 7  7 3 0 2 5 1 6 4
// First puzzle again on a board that has been used
0 0 1 4  0 4 7 5 2 6 1 3

// ==== sim.f ====
hdl/queenPkg.sv
hdl/placementLoader.sv
hdl/attackBoard.sv
hdl/backtrackSearch.sv
hdl/solutionSerializer.sv
hdl/eightQueens.sv
tb/clockGen.sv
tb/eightQueensTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the eight-queens testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=eightQueensSim

verilator --binary --timing -Wno-fatal --top-module eightQueensTb -f sim.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
	echo "Simulation log holds no result"
	exit 1
fi
exit 0

// ==== tb/eightQueensTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module eightQueensTb;

	localparam int MaxRecords = 32;
	localparam int RecWords = 12; // Two fixed queens, then eight columns
	localparam int CyclesPerRecord = 3000;
	localparam string DataFile = "tb/queens_testdata.txt";

	logic clk;
	logic rst_n;
	logic inValid;
	queenPkg::idx_t inRow;
	queenPkg::idx_t inCol;
	logic outValid;
	queenPkg::idx_t out;

	logic [3:0] testMem [0:MaxRecords*RecWords-1];
	queenPkg::idx_t got [0:queenPkg::BoardN-1];
	int numRecords = 0;
	int cycleLimit = 0;
	int cycleCount = 0;
	int puzzlesSent = 0;
	int framesDone = 0;
	int beatCount = 0;
	logic inFrame = 1'b0;
	int valueErrors = 0;
	int frameErrors = 0;
	int loadErrors = 0;

	clockGen u_clockGen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	eightQueens u_eightQueens (
		.clk      (clk),
		.rst_n    (rst_n),
		.inValid  (inValid),
		.inRow    (inRow),
		.inCol    (inCol),
		.outValid (outValid),
		.out      (out)
	);

	function automatic queenPkg::idx_t recWord(input int rec, input int pos);
		return testMem[rec*RecWords + pos][2:0];
	endfunction

	task automatic loadTestData();
		for (int i = 0; i < MaxRecords*RecWords; i++) begin
			testMem[i] = 4'hf; // Unused slots read as no record
		end
		$readmemh(DataFile, testMem);
		numRecords = 0;
		while (numRecords < MaxRecords && testMem[numRecords*RecWords] != 4'hf) begin
			numRecords++;
		end
	endtask

	task automatic checkFixed(input string name, input queenPkg::idx_t row,
			input queenPkg::idx_t col);
		if (got[row] != col) begin
			$display("CHECK FAILED %s fixed row %0d: expected %0d, actual %0d",
				name, row, col, got[row]);
			valueErrors++;
		end
	endtask

	task automatic runPuzzle(input int rec);
		string name;
		int doneBefore;
		queenPkg::idx_t expCol;
		name = $sformatf("puzzle %0d (%0d,%0d)+(%0d,%0d)", rec, recWord(rec, 0),
			recWord(rec, 1), recWord(rec, 2), recWord(rec, 3));
		doneBefore = framesDone;
		@(posedge clk);
		inValid <= 1'b1;
		inRow <= recWord(rec, 0);
		inCol <= recWord(rec, 1);
		@(posedge clk);
		inRow <= recWord(rec, 2);
		inCol <= recWord(rec, 3);
		puzzlesSent <= puzzlesSent + 1;
		@(posedge clk);
		inValid <= 1'b0;
		inRow <= '0;
		inCol <= '0;
		while (framesDone == doneBefore) begin
			@(posedge clk); // Watchdog ends a hung search
		end
		for (int k = 0; k < queenPkg::BoardN; k++) begin
			expCol = recWord(rec, 4 + k);
			if (got[k] != expCol) begin
				$display("CHECK FAILED %s row %0d: expected %0d, actual %0d",
					name, k, expCol, got[k]);
				valueErrors++;
			end
		end
		checkFixed(name, recWord(rec, 0), recWord(rec, 1));
		checkFixed(name, recWord(rec, 2), recWord(rec, 3));
	endtask

	// Output monitor sampling values settled in the previous cycle
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > 0) begin
			if (!outValid) begin
				if (out != '0) begin
					$display("CHECK FAILED idle out: expected 0, actual %0d", out);
					valueErrors++;
				end
				if (inFrame) begin
					if (beatCount != queenPkg::BoardN) begin
						$display("outValid was high for %0d cycles instead of 8", beatCount);
						frameErrors++;
					end
					inFrame <= 1'b0;
					framesDone <= framesDone + 1;
				end
			end else if (!inFrame) begin
				if (framesDone >= puzzlesSent) begin
					$display("outValid rose at cycle %0d with no puzzle pending", cycleCount);
					frameErrors++;
				end
				inFrame <= 1'b1;
				got[0] <= out;
				beatCount <= 1;
			end else if (beatCount >= queenPkg::BoardN) begin
				$display("outValid still high after 8 cycles at cycle %0d", cycleCount);
				frameErrors++;
				beatCount <= beatCount + 1;
			end else begin
				got[beatCount] <= out;
				beatCount <= beatCount + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		inValid = 1'b0;
		inRow = '0;
		inCol = '0;
		loadTestData();
		if (numRecords == 0) begin
			$display("No puzzle records could be read from %s", DataFile);
			loadErrors++;
		end else begin
			cycleLimit = 20 + numRecords * CyclesPerRecord;
			while (!rst_n) begin
				@(posedge clk);
			end
			repeat (3) @(posedge clk);
			for (int r = 0; r < numRecords; r++) begin
				runPuzzle(r);
			end
			repeat (20) @(posedge clk); // Catch stray outValid after the last puzzle
		end
		$display("Puzzles run: %0d, value errors: %0d, framing errors: %0d, load errors: %0d",
			framesDone, valueErrors, frameErrors, loadErrors);
		if (valueErrors == 0 && frameErrors == 0 && loadErrors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rst_n
);

	localparam int HalfPeriod = 10; // 20 ns clock
	localparam int ResetCycles = 10;

	initial begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== hdl/eightQueens.sv ====
`timescale 1ns/1ps
`default_nettype none

module eightQueens (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            inValid,
	input  queenPkg::idx_t  inRow,
	input  queenPkg::idx_t  inCol,
	output logic            outValid,
	output queenPkg::idx_t  out
);

	queenPkg::fixedSet_t fixedSet;
	queenPkg::boardCmd_t loadCmd;
	queenPkg::boardCmd_t searchCmd;
	queenPkg::colVec_t solution;
	queenPkg::idx_t queryRow;
	logic [queenPkg::BoardN-1:0] safeCols;
	logic start;
	logic clear;
	logic solved;

	placementLoader u_placementLoader (
		.clk      (clk),
		.rst_n    (rst_n),
		.inValid  (inValid),
		.inRow    (inRow),
		.inCol    (inCol),
		.fixedSet (fixedSet),
		.loadCmd  (loadCmd),
		.start    (start)
	);

	attackBoard u_attackBoard (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.loadCmd   (loadCmd),
		.searchCmd (searchCmd),
		.queryRow  (queryRow),
		.safeCols  (safeCols)
	);

	backtrackSearch u_backtrackSearch (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.fixedSet  (fixedSet),
		.safeCols  (safeCols),
		.queryRow  (queryRow),
		.searchCmd (searchCmd),
		.clear     (clear),
		.solution  (solution),
		.solved    (solved)
	);

	solutionSerializer u_solutionSerializer (
		.clk      (clk),
		.rst_n    (rst_n),
		.solved   (solved),
		.solution (solution),
		.outValid (outValid),
		.out      (out)
	);

endmodule

`default_nettype wire

// ==== hdl/solutionSerializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module solutionSerializer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               solved,
	input  queenPkg::colVec_t  solution,
	output logic               outValid,
	output queenPkg::idx_t     out
);

	queenPkg::colVec_t held;
	queenPkg::idx_t count;

	always_ff @(posedge clk) begin
		if (solved) begin
			held <= solution;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outValid <= 1'b0;
			out <= '0;
			count <= '0;
		end else if (solved) begin
			outValid <= 1'b1;
			out <= solution[0]; // Row 0 goes out straight away
			count <= 3'd1;
		end else if (outValid) begin
			if (count == '0) begin
				// Wrapped past row 7
				outValid <= 1'b0;
				out <= '0;
			end else begin
				out <= held[count];
				count <= count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/backtrackSearch.sv ====
`timescale 1ns/1ps
`default_nettype none

module backtrackSearch (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         start,
	input  queenPkg::fixedSet_t          fixedSet,
	input  logic [queenPkg::BoardN-1:0]  safeCols,
	output queenPkg::idx_t               queryRow,
	output queenPkg::boardCmd_t          searchCmd,
	output logic                         clear,
	output queenPkg::colVec_t            solution,
	output logic                         solved
);

	localparam queenPkg::idx_t LastRow = queenPkg::idx_t'(queenPkg::BoardN - 1);

	logic busy;
	logic goingUp; // Set on arrival from below so this row's queen comes off first
	queenPkg::idx_t row;
	queenPkg::colVec_t chosen;
	logic [3:0] lowBound; // Lowest column still worth trying in this row

	logic rowIsFixed;
	logic [queenPkg::BoardN-1:0] candidates;
	logic found;
	queenPkg::idx_t pickCol;
	logic stepPlace;
	logic finishNow;

	assign queryRow = row;
	assign rowIsFixed = fixedSet.rowFixed[row];

	always_comb begin
		candidates = '0;
		pickCol = '0;
		for (int c = 0; c < queenPkg::BoardN; c++) begin
			candidates[c] = safeCols[c] && (c >= int'(lowBound));
		end
		for (int c = queenPkg::BoardN - 1; c >= 0; c--) begin
			if (candidates[c]) begin
				pickCol = queenPkg::idx_t'(c); // Lowest wins
			end
		end
		found = |candidates;
	end

	assign stepPlace = busy && !rowIsFixed && !goingUp && found;
	assign finishNow = busy && !goingUp && (row == LastRow) && (rowIsFixed || found);

	// Board takes the command on the same edge that the row moves on
	always_comb begin
		searchCmd = '0;
		if (busy && !rowIsFixed && goingUp) begin
			searchCmd = '{valid: 1'b1, op: queenPkg::OpRemove,
				row: row, col: chosen[row]};
		end else if (stepPlace) begin
			searchCmd = '{valid: 1'b1, op: queenPkg::OpPlace,
				row: row, col: pickCol};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			goingUp <= 1'b0;
			row <= '0;
			solved <= 1'b0;
			clear <= 1'b0;
		end else begin
			solved <= 1'b0;
			clear <= solved; // Empty the board once the answer is out
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					goingUp <= 1'b0;
					row <= '0;
				end
			end else if (rowIsFixed) begin
				if (goingUp) begin
					row <= row - 1'b1;
				end else if (row == LastRow) begin
					busy <= 1'b0;
					solved <= 1'b1;
				end else begin
					row <= row + 1'b1;
				end
			end else if (goingUp) begin
				goingUp <= 1'b0;
			end else if (found) begin
				if (row == LastRow) begin
					busy <= 1'b0;
					solved <= 1'b1;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				goingUp <= 1'b1; // Back up a row from a dead end
				row <= row - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			chosen <= fixedSet.fixedCol; // Fixed rows keep these entries
			lowBound <= '0;
		end else if (busy && !rowIsFixed) begin
			if (goingUp) begin
				lowBound <= {1'b0, chosen[row]} + 4'd1;
			end else if (found) begin
				chosen[row] <= pickCol;
				lowBound <= '0;
			end
		end
		if (finishNow) begin
			solution <= chosen;
			if (stepPlace) begin
				solution[row] <= pickCol;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/attackBoard.sv ====
`timescale 1ns/1ps
`default_nettype none

module attackBoard (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         clear,
	input  queenPkg::boardCmd_t          loadCmd,
	input  queenPkg::boardCmd_t          searchCmd,
	input  queenPkg::idx_t               queryRow,
	output logic [queenPkg::BoardN-1:0]  safeCols
);

	localparam logic [3:0] MinusBase = 4'(queenPkg::BoardN - 1);

	logic [queenPkg::BoardN-1:0] colBusy;
	logic [queenPkg::DiagN-1:0] plusBusy;
	logic [queenPkg::DiagN-1:0] minusBusy;

	queenPkg::boardCmd_t cmd;
	logic [3:0] cmdPlus;
	logic [3:0] cmdMinus;
	logic setBit;

	function automatic logic [3:0] plusDiag(input queenPkg::idx_t r, input queenPkg::idx_t c);
		return {1'b0, r} + {1'b0, c};
	endfunction

	function automatic logic [3:0] minusDiag(input queenPkg::idx_t r, input queenPkg::idx_t c);
		return MinusBase + {1'b0, r} - {1'b0, c};
	endfunction

	// Loader and search never drive a command in the same cycle
	assign cmd = loadCmd.valid ? loadCmd : searchCmd;
	assign cmdPlus = plusDiag(cmd.row, cmd.col);
	assign cmdMinus = minusDiag(cmd.row, cmd.col);
	assign setBit = (cmd.op == queenPkg::OpPlace);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			colBusy <= '0;
			plusBusy <= '0;
			minusBusy <= '0;
		end else if (clear) begin
			colBusy <= '0;
			plusBusy <= '0;
			minusBusy <= '0;
		end else if (cmd.valid) begin
			colBusy[cmd.col] <= setBit;
			plusBusy[cmdPlus] <= setBit;
			minusBusy[cmdMinus] <= setBit;
		end
	end

	// Column is safe when its column and both diagonals are free
	always_comb begin
		for (int c = 0; c < queenPkg::BoardN; c++) begin
			safeCols[c] = !colBusy[c]
				&& !plusBusy[plusDiag(queryRow, queenPkg::idx_t'(c))]
				&& !minusBusy[minusDiag(queryRow, queenPkg::idx_t'(c))];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/placementLoader.sv ====
`timescale 1ns/1ps
`default_nettype none

module placementLoader (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 inValid,
	input  queenPkg::idx_t       inRow,
	input  queenPkg::idx_t       inCol,
	output queenPkg::fixedSet_t  fixedSet,
	output queenPkg::boardCmd_t  loadCmd,
	output logic                 start
);

	typedef enum logic [1:0] {
		LdIdle,
		LdSecond,
		LdLast
	} ldState_t;

	ldState_t state;
	queenPkg::placement_t inQueen;

	assign inQueen = '{row: inRow, col: inCol};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= LdIdle;
			fixedSet <= '0;
			loadCmd <= '0;
			start <= 1'b0;
		end else begin
			loadCmd.valid <= 1'b0;
			start <= 1'b0;
			case (state)
				LdIdle: begin
					if (inValid) begin
						// First queen opens a new puzzle
						fixedSet.rowFixed <= '0;
						fixedSet.rowFixed[inQueen.row] <= 1'b1;
						fixedSet.fixedCol[inQueen.row] <= inQueen.col;
						loadCmd <= '{valid: 1'b1, op: queenPkg::OpPlace,
							row: inQueen.row, col: inQueen.col};
						state <= LdSecond;
					end
				end
				LdSecond: begin
					if (inValid) begin
						fixedSet.rowFixed[inQueen.row] <= 1'b1;
						fixedSet.fixedCol[inQueen.row] <= inQueen.col;
						loadCmd <= '{valid: 1'b1, op: queenPkg::OpPlace,
							row: inQueen.row, col: inQueen.col};
						state <= LdLast;
					end else begin
						state <= LdIdle; // Drop a broken pair
					end
				end
				LdLast: begin
					start <= 1'b1; // Board holds both queens by now
					state <= LdIdle;
				end
				default: state <= LdIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/queenPkg.sv ====
`default_nettype none

package queenPkg;

	localparam int BoardN = 8;
	localparam int DiagN = 2 * BoardN - 1; // 15 diagonals per direction

	localparam logic OpPlace = 1'b0;
	localparam logic OpRemove = 1'b1;

	typedef logic [2:0] idx_t;

	typedef struct packed {
		idx_t row;
		idx_t col;
	} placement_t;

	// Puzzle as captured from the two input cycles
	typedef struct packed {
		logic [BoardN-1:0] rowFixed;
		idx_t [BoardN-1:0] fixedCol;
	} fixedSet_t;

	typedef struct packed {
		logic valid;
		logic op; // OpPlace or OpRemove
		idx_t row;
		idx_t col;
	} boardCmd_t;

	typedef idx_t [BoardN-1:0] colVec_t;

endpackage

`default_nettype wire
